// File: source/u1e_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, address map and types of the host core
// settings register index is the halfword offset over two
////////////////////////////////////////////////////////////
`default_nettype none

package u1e_pkg;

   ////////////////////////////////////////////////////////////
   // host bus and address map
   localparam int HADDR_W    = 11;   // halfword address
   localparam int HDATA_W    = 16;
   localparam int SET_ADDR_W = 8;
   localparam int REGION_W   = 4;    // top bits of the halfword address

   localparam logic [REGION_W-1:0] REGION_MISC          = 4'd0;
   localparam logic [REGION_W-1:0] REGION_READBACK      = 4'd7;
   localparam logic [REGION_W-1:0] REGION_SETTINGS      = 4'd8;
   localparam logic [REGION_W-1:0] REGION_SETTINGS_MASK = 4'hE;  // 8 and 9, double wide

   ////////////////////////////////////////////////////////////
   // settings register addresses
   localparam logic [SET_ADDR_W-1:0] SR_TIME64       = 8'd42;  // +0 hi, +1 lo, +2 ctrl
   localparam logic [SET_ADDR_W-1:0] SR_REG_TEST32   = 8'd60;
   localparam logic [SET_ADDR_W-1:0] SR_GLOBAL_RESET = 8'd63;

   // misc slave, halfword offsets
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;    // read only
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;   // read only

   localparam logic [7:0]         COMPAT_NUM         = 8'd6;
   localparam logic [1:0]         CGEN_CTRL_RESET    = 2'b11;  // sync_b and ref_sel high
   localparam logic [HDATA_W-1:0] MISC_UNMAPPED_DATA = 16'hBEEF;

   // readback words, the rest read as zero
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;

   ////////////////////////////////////////////////////////////
   // types
   typedef logic [HADDR_W-1:0] host_addr_t;
   typedef logic [HDATA_W-1:0] host_data_t;
   typedef logic [31:0]        set_data_t;
   typedef logic [63:0]        vita_time_t;

   // stb is a single cycle pulse, addr and data valid with it
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      set_data_t             data;
   } set_bus_t;

   typedef enum logic [1:0] {MISC, READBACK, SETTINGS, NONE} slave_e;

   typedef enum logic {IDLE, WAIT_ACK} decode_state_e;

endpackage

`default_nettype wire

// File: source/host_bus_if.sv
////////////////////////////////////////////////////////////
// one request/acknowledge register slave port
// req held until ack, ack is a single cycle pulse
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface host_bus_if;

   logic                req;
   logic                write;
   u1e_pkg::host_addr_t addr;    // slave keeps only the offset bits it owns
   u1e_pkg::host_data_t wdata;
   u1e_pkg::host_data_t rdata;   // valid while ack is high
   logic                ack;

   modport master (output req, write, addr, wdata, input rdata, ack);

   modport slave (input req, write, addr, wdata, output rdata, ack);

endinterface

`default_nettype wire

// File: source/host_decode.sv
////////////////////////////////////////////////////////////
// apb slave, one open slave request per access phase
// unmapped regions finish at once with pslverr
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module host_decode
  (
   input  logic                 wb_clk,
   input  logic                 rst_i,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  u1e_pkg::host_addr_t  paddr_i,
   input  u1e_pkg::host_data_t  pwdata_i,
   output u1e_pkg::host_data_t  prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   host_bus_if.master           misc_bus,
   host_bus_if.master           rb_bus,
   host_bus_if.master           set_bus
   );

   u1e_pkg::decode_state_e       state_q;
   u1e_pkg::slave_e              slave;
   logic [u1e_pkg::REGION_W-1:0] region;
   logic                         access;
   logic                         req;
   logic                         ack;

   assign region = paddr_i[u1e_pkg::HADDR_W-1 -: u1e_pkg::REGION_W];
   assign access = psel_i & penable_i;     // apb access phase

   always_comb
   begin
      if (region == u1e_pkg::REGION_MISC)
         slave = u1e_pkg::MISC;
      else if (region == u1e_pkg::REGION_READBACK)
         slave = u1e_pkg::READBACK;
      else if ((region & u1e_pkg::REGION_SETTINGS_MASK) == u1e_pkg::REGION_SETTINGS)
         slave = u1e_pkg::SETTINGS;
      else
         slave = u1e_pkg::NONE;
   end

   // request opens in the first access cycle and stays until ack
   assign req = (state_q == u1e_pkg::WAIT_ACK) | (access & (slave != u1e_pkg::NONE));

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         state_q <= u1e_pkg::IDLE;
      else
         case (state_q)
            u1e_pkg::IDLE:
               if (req && !ack)
                  state_q <= u1e_pkg::WAIT_ACK;
            default:
               if (ack)
                  state_q <= u1e_pkg::IDLE;
         endcase
   end

   ////////////////////////////////////////////////////////////
   // slave side
   assign misc_bus.req   = req & (slave == u1e_pkg::MISC);
   assign misc_bus.write = pwrite_i;
   assign misc_bus.addr  = paddr_i;
   assign misc_bus.wdata = pwdata_i;
   assign rb_bus.req     = req & (slave == u1e_pkg::READBACK);
   assign rb_bus.write   = pwrite_i;
   assign rb_bus.addr    = paddr_i;
   assign rb_bus.wdata   = pwdata_i;
   assign set_bus.req    = req & (slave == u1e_pkg::SETTINGS);
   assign set_bus.write  = pwrite_i;
   assign set_bus.addr   = paddr_i;
   assign set_bus.wdata  = pwdata_i;

   always_comb
   begin
      case (slave)
         u1e_pkg::MISC:     ack = misc_bus.ack;
         u1e_pkg::READBACK: ack = rb_bus.ack;
         u1e_pkg::SETTINGS: ack = set_bus.ack;
         default:           ack = 1'b0;
      endcase
   end

   always_comb
   begin
      case (slave)
         u1e_pkg::MISC:     prdata_o = misc_bus.rdata;
         u1e_pkg::READBACK: prdata_o = rb_bus.rdata;
         u1e_pkg::SETTINGS: prdata_o = set_bus.rdata;
         default:           prdata_o = '0;    // error reads return zero
      endcase
   end

   assign pready_o  = access & ((slave == u1e_pkg::NONE) | ack);
   assign pslverr_o = access & (slave == u1e_pkg::NONE);

endmodule

`default_nettype wire

// File: source/misc_regs.sv
////////////////////////////////////////////////////////////
// misc control and status, 7 bit halfword offsets
// unmapped offsets read BEEF, read only ones ignore writes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module misc_regs
  (
   input  logic      wb_clk,
   input  logic      rst_i,
   input  logic      cgen_st_status_i,
   input  logic      cgen_st_ld_i,
   input  logic      cgen_st_refmon_i,
   host_bus_if.slave bus,
   output logic      cgen_sync_b_o,
   output logic      cgen_ref_sel_o
   );

   u1e_pkg::host_data_t reg_leds;
   u1e_pkg::host_data_t reg_cgen_ctrl;
   u1e_pkg::host_data_t reg_test;
   logic [6:0]          offset;
   logic                wr_en;

   assign offset = bus.addr[6:0];
   assign wr_en  = bus.req & bus.write & ~bus.ack;   // once per request

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= u1e_pkg::host_data_t'(u1e_pkg::CGEN_CTRL_RESET);
         reg_test      <= '0;
         bus.ack       <= 1'b0;
      end
      else
      begin
         bus.ack <= bus.req & ~bus.ack;
         if (wr_en)
            case (offset)
               u1e_pkg::REG_LEDS:      reg_leds      <= bus.wdata;
               u1e_pkg::REG_CGEN_CTRL: reg_cgen_ctrl <= bus.wdata;
               u1e_pkg::REG_TEST:      reg_test      <= bus.wdata;
               default: ;
            endcase
      end
   end

   always_comb
   begin
      case (offset)
         u1e_pkg::REG_LEDS:      bus.rdata = reg_leds;
         u1e_pkg::REG_CGEN_CTRL: bus.rdata = reg_cgen_ctrl;
         u1e_pkg::REG_CGEN_ST:
            bus.rdata = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         u1e_pkg::REG_TEST:      bus.rdata = reg_test;
         u1e_pkg::REG_COMPAT:    bus.rdata = {8'd0, u1e_pkg::COMPAT_NUM};
         default:                bus.rdata = u1e_pkg::MISC_UNMAPPED_DATA;
      endcase
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];  // sync_b is bit 1

endmodule

`default_nettype wire

// File: source/settings_bus.sv
////////////////////////////////////////////////////////////
// 16 bit little endian writes into 32 bit settings
// low halfword first, the high halfword fires the strobe
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module settings_bus
  (
   input  logic              wb_clk,
   input  logic              wb_rst,
   host_bus_if.slave         bus,
   output u1e_pkg::set_bus_t set_o,
   output logic              soft_rst_o
   );

   u1e_pkg::host_data_t             low_q;    // pending low halfword
   logic                            stb_q;
   logic [u1e_pkg::SET_ADDR_W-1:0]  addr_q;
   u1e_pkg::set_data_t              data_q;
   logic                            soft_rst_q;
   logic                            wr_lo;
   logic                            wr_hi;

   assign wr_lo = bus.ack & bus.write & ~bus.addr[0];
   assign wr_hi = bus.ack & bus.write & bus.addr[0];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         bus.ack    <= 1'b0;
         stb_q      <= 1'b0;
         soft_rst_q <= 1'b0;
      end
      else
      begin
         bus.ack    <= bus.req & ~bus.ack;
         stb_q      <= wr_hi;
         soft_rst_q <= stb_q & (addr_q == u1e_pkg::SR_GLOBAL_RESET);
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         low_q <= bus.wdata;
      if (wr_hi)
      begin
         addr_q <= bus.addr[u1e_pkg::SET_ADDR_W:1];   // halfword offset / 2
         data_q <= {bus.wdata, low_q};
      end
   end

   assign set_o      = '{stb: stb_q, addr: addr_q, data: data_q};
   assign soft_rst_o = soft_rst_q;
   assign bus.rdata  = '0;        // write only

endmodule

`default_nettype wire

// File: source/vita_time.sv
////////////////////////////////////////////////////////////
// 64 bit time in raw clock ticks, no seconds split
// pps_i is asynchronous, edges seen two cycles late
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vita_time
  (
   input  logic                wb_clk,
   input  logic                rst_i,
   input  logic                pps_i,
   input  u1e_pkg::set_bus_t   set_i,
   output u1e_pkg::vita_time_t time_o,
   output u1e_pkg::vita_time_t time_pps_o
   );

   logic                pps_meta;
   logic                pps_sync;
   logic                pps_prev;
   logic                pps_edge;
   logic                armed_q;      // load waits for next pps
   logic                load_now;
   logic                load_arm;
   u1e_pkg::set_data_t  load_hi;
   u1e_pkg::set_data_t  load_lo;
   u1e_pkg::vita_time_t time_q;
   u1e_pkg::vita_time_t time_pps_q;

   assign pps_edge = pps_sync & ~pps_prev;
   assign load_now = set_i.stb && (set_i.addr == u1e_pkg::SR_TIME64 + 8'd2) && set_i.data[0];
   assign load_arm = set_i.stb && (set_i.addr == u1e_pkg::SR_TIME64 + 8'd2) && !set_i.data[0];

   // pending load words
   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == u1e_pkg::SR_TIME64)
         load_hi <= set_i.data;
      if (set_i.stb && set_i.addr == u1e_pkg::SR_TIME64 + 8'd1)
         load_lo <= set_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         pps_meta   <= 1'b0;
         pps_sync   <= 1'b0;
         pps_prev   <= 1'b0;
         armed_q    <= 1'b0;
         time_q     <= '0;
         time_pps_q <= '0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;

         if (load_now || (pps_edge && armed_q))
            time_q <= {load_hi, load_lo};
         else
            time_q <= time_q + 64'd1;

         if (pps_edge)
            time_pps_q <= armed_q ? {load_hi, load_lo} : time_q;

         if (load_arm)
            armed_q <= 1'b1;
         else if (load_now || pps_edge)
            armed_q <= 1'b0;   // consumed or overridden
      end
   end

   assign time_o     = time_q;
   assign time_pps_o = time_pps_q;

endmodule

`default_nettype wire

// File: source/readback_mux.sv
////////////////////////////////////////////////////////////
// 32 bit readback words as halfwords, low half at even
// the two time halves are separate reads, no snapshot
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module readback_mux
  (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  u1e_pkg::set_bus_t   set_i,
   input  u1e_pkg::vita_time_t time_i,
   input  u1e_pkg::vita_time_t time_pps_i,
   host_bus_if.slave           bus
   );

   u1e_pkg::set_data_t test32_q;   // survives the global reset
   u1e_pkg::set_data_t word;
   logic               rd_q;       // data stage before the ack

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         test32_q <= '0;
      else if (set_i.stb && set_i.addr == u1e_pkg::SR_REG_TEST32)
         test32_q <= set_i.data;
   end

   always_comb
   begin
      case (bus.addr[4:1])
         u1e_pkg::RB_TIME_HI: word = time_i[63:32];
         u1e_pkg::RB_TIME_LO: word = time_i[31:0];
         u1e_pkg::RB_PPS_HI:  word = time_pps_i[63:32];
         u1e_pkg::RB_PPS_LO:  word = time_pps_i[31:0];
         u1e_pkg::RB_TEST32:  word = test32_q;
         default:             word = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         rd_q    <= 1'b0;
         bus.ack <= 1'b0;
      end
      else
      begin
         rd_q    <= bus.req & ~rd_q & ~bus.ack;
         bus.ack <= rd_q;            // two cycles after req
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (rd_q)
         bus.rdata <= bus.addr[0] ? word[31:16] : word[15:0];
   end

endmodule

`default_nettype wire

// File: source/u1e_core.sv
////////////////////////////////////////////////////////////
// host control core, apb slave over three register slaves
// settings write to the global reset clears all but test32
// and the settings bus itself
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module u1e_core
  (
   input  logic                wb_clk,
   input  logic                wb_rst,
   // apb
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  u1e_pkg::host_addr_t paddr_i,
   input  u1e_pkg::host_data_t pwdata_i,
   output u1e_pkg::host_data_t prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   // board
   input  logic                pps_i,
   input  logic                cgen_st_status_i,
   input  logic                cgen_st_ld_i,
   input  logic                cgen_st_refmon_i,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o
   );

   u1e_pkg::set_bus_t   set_w;
   u1e_pkg::vita_time_t time_w;
   u1e_pkg::vita_time_t time_pps_w;
   logic                soft_rst;
   logic                core_rst;

   assign core_rst = wb_rst | soft_rst;  // software global reset

   host_bus_if misc_bus ();
   host_bus_if rb_bus ();
   host_bus_if set_bus ();

   ////////////////////////////////////////////////////////////
   // host side
   host_decode host_decode
     (.wb_clk(wb_clk), .rst_i(core_rst),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i),
      .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
      .misc_bus(misc_bus), .rb_bus(rb_bus), .set_bus(set_bus));

   misc_regs misc_regs
     (.wb_clk(wb_clk), .rst_i(core_rst),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .bus(misc_bus),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   ////////////////////////////////////////////////////////////
   // settings, timing and readback
   settings_bus settings_bus
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus(set_bus),
      .set_o(set_w), .soft_rst_o(soft_rst));

   vita_time vita_time
     (.wb_clk(wb_clk), .rst_i(core_rst), .pps_i(pps_i), .set_i(set_w),
      .time_o(time_w), .time_pps_o(time_pps_w));

   readback_mux readback_mux
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_w),
      .time_i(time_w), .time_pps_i(time_pps_w), .bus(rb_bus));

endmodule

`default_nettype wire

// File: verification/u1e_props.sv
////////////////////////////////////////////////////////////
// apb and settings handshake properties
// bound twice, unused inputs are tied low
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module u1e_props
  (
   input logic                   wb_clk,
   input logic                   rst_i,
   input logic                   psel_i,
   input logic                   penable_i,
   input logic                   pready_i,
   input logic                   pwrite_i,
   input u1e_pkg::host_addr_t    paddr_i,
   input u1e_pkg::host_data_t    pwdata_i,
   input u1e_pkg::decode_state_e state_i,
   input logic                   req_i,
   input logic                   ack_i,
   input logic                   stb_i
   );

   assert property (@(posedge wb_clk) disable iff (rst_i) pready_i |=> !pready_i)
      else $error("pready stayed high for more than one cycle");

   // master keeps the transfer steady until pready
   assert property (@(posedge wb_clk) disable iff (rst_i)
                    psel_i && penable_i && !pready_i |=> psel_i && penable_i &&
                    $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
      else $error("apb access phase changed before pready");

   assert property (@(posedge wb_clk) disable iff (rst_i) stb_i |=> !stb_i)
      else $error("settings strobe longer than one cycle");

   // slave side request stays up while no ack has come
   assert property (@(posedge wb_clk) disable iff (rst_i)
                    (req_i || state_i == u1e_pkg::WAIT_ACK) && !ack_i |=> req_i)
      else $error("request dropped before its acknowledge");

endmodule

bind host_decode u1e_props decode_props
  (.wb_clk(wb_clk), .rst_i(rst_i), .psel_i(psel_i), .penable_i(penable_i),
   .pready_i(pready_o), .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
   .state_i(state_q), .req_i(misc_bus.req | rb_bus.req | set_bus.req), .ack_i(ack),
   .stb_i(1'b0));

bind settings_bus u1e_props set_props
  (.wb_clk(wb_clk), .rst_i(wb_rst), .psel_i(1'b0), .penable_i(1'b0),
   .pready_i(1'b0), .pwrite_i(1'b0), .paddr_i('0), .pwdata_i('0),
   .state_i(u1e_pkg::IDLE), .req_i(bus.req), .ack_i(bus.ack), .stb_i(set_o.stb))

;

`default_nettype wire

// File: verification/u1e_monitor.sv
////////////////////////////////////////////////////////////
// checker for apb completions and the cgen pins
// expectation is held steady by the driver for each test
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module u1e_monitor
  (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pready_i,
   input  logic                pslverr_i,
   input  u1e_pkg::host_data_t prdata_i,
   input  logic                cgen_sync_b_i,
   input  logic                cgen_ref_sel_i,
   input  logic [8*20-1:0]     exp_name_i,
   input  logic [1:0]          exp_mode_i,     // 0 write, 1 exact, 2 within 200 above
   input  u1e_pkg::host_data_t exp_data_i,
   input  logic                exp_err_i,
   input  logic                pin_chk_i,
   output int                  pass_cnt_o,
   output int                  fail_cnt_o
   );

   int   act_v;
   int   exp_v;
   logic pins_ok;

   always @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pass_cnt_o = 0;
         fail_cnt_o = 0;
      end
      else if (pin_chk_i)
      begin
         pins_ok = ({cgen_sync_b_i, cgen_ref_sel_i} == exp_data_i[1:0]);
         if (pins_ok)
         begin
            $display("%0s passed", exp_name_i);
            pass_cnt_o = pass_cnt_o + 1;
         end
         else
         begin
            $display("Error: %0s cgen pins expected %02b actual %02b", exp_name_i,
                     exp_data_i[1:0], {cgen_sync_b_i, cgen_ref_sel_i});
            fail_cnt_o = fail_cnt_o + 1;
         end
      end
      else if (psel_i && penable_i && pready_i)
      begin
         act_v = int'(prdata_i);
         exp_v = exp_err_i ? 0 : int'(exp_data_i);   // error transfers return zero
         if (pslverr_i != exp_err_i)
         begin
            $display("Error: %0s pslverr expected %0d actual %0d", exp_name_i,
                     exp_err_i, pslverr_i);
            fail_cnt_o = fail_cnt_o + 1;
         end
         else if (exp_mode_i == 2'd2 && (act_v < exp_v || act_v >= exp_v + 200))
         begin
            $display("Error: %0s expected %04h to %04h actual %04h", exp_name_i,
                     exp_v, exp_v + 199, act_v);
            fail_cnt_o = fail_cnt_o + 1;
         end
         else if ((exp_mode_i == 2'd1 || exp_err_i) && act_v != exp_v)
         begin
            $display("Error: %0s expected %04h actual %04h", exp_name_i, exp_v, act_v);
            fail_cnt_o = fail_cnt_o + 1;
         end
         else
         begin
            $display("%0s passed", exp_name_i);
            pass_cnt_o = pass_cnt_o + 1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/tb_u1e_core.sv
////////////////////////////////////////////////////////////
// testbench for u1e_core, apb transfers from a text file
// one transfer in flight, random idle gaps between them
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_u1e_core;

   logic                wb_clk;
   logic                wb_rst;
   logic                psel;
   logic                penable;
   logic                pwrite;
   u1e_pkg::host_addr_t paddr;
   u1e_pkg::host_data_t pwdata;
   u1e_pkg::host_data_t prdata;
   logic                pready;
   logic                pslverr;
   logic                pps;
   logic                cgen_st_status;
   logic                cgen_st_ld;
   logic                cgen_st_refmon;
   logic                cgen_sync_b;
   logic                cgen_ref_sel;

   // expectation of the running test, sampled by the monitor
   logic [8*20-1:0]     exp_name;
   logic [1:0]          exp_mode;     // 0 write, 1 exact read, 2 read within 200 above
   u1e_pkg::host_data_t exp_data;
   logic                exp_err;
   logic                pin_chk;
   int                  pass_cnt;
   int                  fail_cnt;
   logic                done_q;       // completion seen on the last rising edge
   logic                timed_out;
   int                  checks;
   int                  bad_lines;

   u1e_core dut_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
      .pps_i(pps), .cgen_st_status_i(cgen_st_status), .cgen_st_ld_i(cgen_st_ld),
      .cgen_st_refmon_i(cgen_st_refmon),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel));

   u1e_monitor monitor_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .psel_i(psel), .penable_i(penable), .pready_i(pready), .pslverr_i(pslverr),
      .prdata_i(prdata), .cgen_sync_b_i(cgen_sync_b), .cgen_ref_sel_i(cgen_ref_sel),
      .exp_name_i(exp_name), .exp_mode_i(exp_mode), .exp_data_i(exp_data),
      .exp_err_i(exp_err), .pin_chk_i(pin_chk),
      .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt));

   initial
   begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      done_q <= psel & penable & pready;

   ////////////////////////////////////////////////////////////
   // stimulus tasks, all called on a falling edge
   task automatic apb_xfer(input logic wr, input logic [1:0] mode,
                           input logic [8*20-1:0] name, input u1e_pkg::host_addr_t addr,
                           input u1e_pkg::host_data_t data, input logic err);
      int gap;
      int waited;
      gap = $urandom_range(3, 0);
      repeat (gap) @(negedge wb_clk);
      exp_name = name;
      exp_mode = mode;
      exp_data = data;
      exp_err  = err;
      psel     = 1'b1;       // setup phase
      penable  = 1'b0;
      pwrite   = wr;
      paddr    = addr;
      pwdata   = wr ? data : '0;
      @(negedge wb_clk);
      penable  = 1'b1;
      waited   = 0;
      do
      begin
         @(negedge wb_clk);
         waited++;
      end
      while (!done_q && waited < 50);
      psel     = 1'b0;
      penable  = 1'b0;
      if (!done_q)
      begin
         $display("timeout, no pready within 50 cycles on test %0s", name);
         timed_out = 1'b1;
      end
      checks++;
   endtask

   task automatic check_pins(input logic [8*20-1:0] name, input u1e_pkg::host_data_t exp);
      exp_name = name;
      exp_data = exp;       // {sync_b, ref_sel} in the low bits
      exp_mode = 2'd0;
      exp_err  = 1'b0;
      pin_chk  = 1'b1;
      @(negedge wb_clk);
      pin_chk  = 1'b0;
      checks++;
   endtask

   // pps edge reaches the time core two cycles after it rises
   task automatic pulse_pps();
      pps = 1'b1;
      repeat (4) @(negedge wb_clk);
      pps = 1'b0;
      repeat (4) @(negedge wb_clk);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   initial
   begin
      int                  fd;
      int                  code;
      int unsigned         seed;
      logic [8*20-1:0]     name_v;
      logic [8*80-1:0]     rest_v;
      logic [7:0]          op_v;
      u1e_pkg::host_addr_t addr_v;
      u1e_pkg::host_data_t data_v;
      logic                err_v;

      seed           = $urandom(32'h0bde_ec3b);
      wb_rst         = 1'b1;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      pps            = 1'b0;
      cgen_st_status = 1'b0;
      cgen_st_ld     = 1'b0;
      cgen_st_refmon = 1'b0;
      exp_name       = '0;
      exp_mode       = 2'd0;
      exp_data       = '0;
      exp_err        = 1'b0;
      pin_chk        = 1'b0;
      timed_out      = 1'b0;
      checks         = 0;
      bad_lines      = 0;
      repeat (4) @(negedge wb_clk);
      wb_rst = 1'b0;
      @(negedge wb_clk);

      fd = $fopen("verification/u1e_input.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the stimulus file verification/u1e_input.txt");
         bad_lines = 1;
      end
      else
      begin
         while (!timed_out && $fscanf(fd, "%s", name_v) == 1)
         begin
            if (name_v[7:0] == "#" && name_v[8*20-1:8] == '0)
               code = $fgets(rest_v, fd);      // comment line
            else
            begin
               code = $fscanf(fd, "%s %h %h %h", op_v, addr_v, data_v, err_v);
               if (code != 4)
                  op_v = "?";
               case (op_v)
                  "w": apb_xfer(1'b1, 2'd0, name_v, addr_v, data_v, err_v);
                  "r": apb_xfer(1'b0, 2'd1, name_v, addr_v, data_v, err_v);
                  "n": apb_xfer(1'b0, 2'd2, name_v, addr_v, data_v, err_v);
                  "c": check_pins(name_v, data_v);
                  "p": pulse_pps();
                  "s": {cgen_st_status, cgen_st_ld, cgen_st_refmon} = data_v[2:0];
                  default:
                  begin
                     $display("malformed line in the stimulus file at test %0s", name_v);
                     bad_lines++;
                  end
               endcase
            end
         end
         $fclose(fd);
      end

      repeat (2) @(negedge wb_clk);
      $display("tests passed %0d failed %0d of %0d", pass_cnt, fail_cnt, checks);
      if (timed_out || bad_lines != 0 || fail_cnt != 0 || pass_cnt != checks)
         $display("Checks failed");
      else
         $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/u1e_input.txt
# name op addr data err, op w write r read n read at most 199 above
# c cgen pins {sync_b,ref_sel} s status pins p pps pulse, addr data hex
rst_cgen_pins     c 000 0003 0
rst_cgen_ctrl     r 004 0003 0
leds_write        w 000 00a5 0
leds_read         r 000 00a5 0
cgen_write        w 004 0001 0
cgen_pins         c 000 0001 0
cgen_read         r 004 0001 0
test_write        w 008 5a5a 0
test_read         r 008 5a5a 0
compat_read       r 010 0006 0
misc_unmapped     r 002 beef 0
status_drive      s 000 0005 0
status_read       r 006 0005 0
region3_read      r 180 0000 1
region3_write     w 180 1234 1
test32_lo         w 478 1234 0
test32_hi         w 479 cafe 0
rb_test32_lo      r 388 1234 0
rb_test32_hi      r 389 cafe 0
rb_unused         r 392 0000 0
greset_lo         w 47e 0001 0
greset_hi         w 47f 0000 0
greset_test       r 008 0000 0
greset_cgen       r 004 0003 0
greset_pins       c 000 0003 0
greset_t32_lo     r 388 1234 0
greset_t32_hi     r 389 cafe 0
pps_hi_lo         w 454 4567 0
pps_hi_hi         w 455 0123 0
pps_lo_lo         w 456 cdef 0
pps_lo_hi         w 457 89ab 0
pps_arm_lo        w 458 0000 0
pps_arm_hi        w 459 0000 0
pps_pulse         p 000 0000 0
pps_word_hi_lo    r 384 4567 0
pps_word_hi_hi    r 385 0123 0
pps_word_lo_lo    r 386 cdef 0
pps_word_lo_hi    r 387 89ab 0
now_hi_lo         w 454 0012 0
now_hi_hi         w 455 0000 0
now_lo_lo         w 456 0000 0
now_lo_hi         w 457 0010 0
now_ctrl_lo       w 458 0001 0
now_ctrl_hi       w 459 0000 0
time_lo_lo        n 382 0000 0
time_lo_hi        r 383 0010 0
time_hi_lo        r 380 0012 0
time_hi_hi        r 381 0000 0

// File: build.f
source/u1e_pkg.sv
source/host_bus_if.sv
source/host_decode.sv
source/misc_regs.sv
source/settings_bus.sv
source/vita_time.sv
source/readback_mux.sv
source/u1e_core.sv
verification/u1e_props.sv
verification/u1e_monitor.sv
verification/tb_u1e_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the u1e core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_u1e_core \
   -f build.f -o sim_u1e > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_u1e > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

grep -q "All checks passed" sim.log || exit 1
exit 0
